// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Core word width in bits.
`define CORE_XLEN 64

`define CORE_PC_INIT 64'h0  // First fetch address.

`define CORE_INST_LEN 4     // Bytes per instruction.

// Memory depths as log2 of words.
`define CORE_IMEM_AW 8      // Instruction words.
`define CORE_DMEM_AW 8      // Doublewords.

`endif

// ==== design/core_pkg.sv ====
`default_nettype none

`include "core_settings.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_COPY_B  // Passes b through, for LUI.
  } alu_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

  typedef enum logic {A_RS1, A_PC} alu_a_sel_e;
  typedef enum logic {B_RS2, B_IMM} alu_b_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_SNPC} wb_sel_e;

  typedef struct packed {
    imm_kind_e  imm_kind;
    alu_op_e    alu_op;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    wb_sel_e    wb_sel;
    logic       reg_wen;
    logic       mem_wen;
    logic       mem_ren;
    logic       pc_from_alu;  // Jumps and taken branches.
    logic       halt;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    xlen_t    pc;
    inst_t    inst;
    logic     rd_wen;
    reg_idx_t rd;
    xlen_t    rd_data;
  } retire_t;

endpackage

`default_nettype wire

// ==== design/control.sv ====
`default_nettype none

module control (
  input  core_pkg::inst_t inst,
  input  core_pkg::xlen_t rs1_data,
  input  core_pkg::xlen_t rs2_data,
  output core_pkg::ctrl_t ctrl
);
  import core_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam inst_t      INST_EBREAK = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       eq, lt, ltu, taken;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (funct3)
      3'b000:  taken = eq;   // BEQ.
      3'b001:  taken = !eq;  // BNE.
      3'b100:  taken = lt;
      3'b101:  taken = !lt;
      3'b110:  taken = ltu;
      3'b111:  taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl = '0;  // ADD on rs1 and rs2, no side effects.
    case (opcode)
      OPC_LUI: begin
        ctrl.imm_kind  = IMM_U;
        ctrl.alu_op    = ALU_COPY_B;
        ctrl.alu_b_sel = B_IMM;
        ctrl.reg_wen   = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.imm_kind  = IMM_U;
        ctrl.alu_a_sel = A_PC;
        ctrl.alu_b_sel = B_IMM;
        ctrl.reg_wen   = 1'b1;
      end
      OPC_JAL: begin
        ctrl.imm_kind    = IMM_J;
        ctrl.alu_a_sel   = A_PC;
        ctrl.alu_b_sel   = B_IMM;
        ctrl.wb_sel      = WB_SNPC;
        ctrl.reg_wen     = 1'b1;
        ctrl.pc_from_alu = 1'b1;
      end
      OPC_JALR: begin
        ctrl.imm_kind    = IMM_I;
        ctrl.alu_b_sel   = B_IMM;
        ctrl.wb_sel      = WB_SNPC;
        ctrl.reg_wen     = 1'b1;
        ctrl.pc_from_alu = 1'b1;
        ctrl.illegal     = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.imm_kind    = IMM_B;
        ctrl.alu_a_sel   = A_PC;
        ctrl.alu_b_sel   = B_IMM;
        ctrl.pc_from_alu = taken;
        ctrl.illegal     = (funct3[2:1] == 2'b01);  // No branch at 010, 011.
      end
      OPC_LOAD: begin
        ctrl.imm_kind  = IMM_I;
        ctrl.alu_b_sel = B_IMM;
        ctrl.wb_sel    = WB_MEM;
        ctrl.mem_ren   = 1'b1;
        ctrl.reg_wen   = 1'b1;
        ctrl.illegal   = (funct3 != 3'b011);  // LD only.
      end
      OPC_STORE: begin
        ctrl.imm_kind  = IMM_S;
        ctrl.alu_b_sel = B_IMM;
        ctrl.mem_wen   = 1'b1;
        ctrl.illegal   = (funct3 != 3'b011);  // SD only.
      end
      OPC_OP_IMM: begin
        ctrl.imm_kind  = IMM_I;
        ctrl.alu_b_sel = B_IMM;
        ctrl.alu_op    = arith_op(funct3, (funct3 == 3'b101) && inst[30]);
        ctrl.reg_wen   = 1'b1;
        if (funct3 == 3'b001) begin
          ctrl.illegal = (inst[31:26] != 6'b000000);
        end else if (funct3 == 3'b101) begin
          ctrl.illegal = (inst[31:26] != 6'b000000) && (inst[31:26] != 6'b010000);
        end
      end
      OPC_OP: begin
        ctrl.alu_op  = arith_op(funct3, funct7[5]);
        ctrl.reg_wen = 1'b1;
        ctrl.illegal = !((funct7 == 7'b0000000) ||
                         ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      default: begin
        ctrl.halt    = (inst == INST_EBREAK);
        ctrl.illegal = (inst != INST_EBREAK);
      end
    endcase

    // An unknown encoding halts like EBREAK and changes no state.
    if (ctrl.illegal) begin
      ctrl.reg_wen     = 1'b0;
      ctrl.mem_wen     = 1'b0;
      ctrl.mem_ren     = 1'b0;
      ctrl.pc_from_alu = 1'b0;
      ctrl.halt        = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/imm_gen.sv ====
`default_nettype none

`include "core_settings.svh"

module imm_gen (
  input  core_pkg::inst_t     inst,
  input  core_pkg::imm_kind_e kind,
  output core_pkg::xlen_t     imm
);
  import core_pkg::*;

  logic sign;

  assign sign = inst[31];

  always_comb begin
    case (kind)
      IMM_I: imm = {{(`CORE_XLEN-12){sign}}, inst[31:20]};
      IMM_S: imm = {{(`CORE_XLEN-12){sign}}, inst[31:25], inst[11:7]};
      IMM_B: begin
        imm = {{(`CORE_XLEN-13){sign}}, inst[31], inst[7], inst[30:25],
               inst[11:8], 1'b0};  // Halfword offset.
      end
      IMM_U: imm = {{(`CORE_XLEN-32){sign}}, inst[31:12], 12'b0};
      IMM_J: begin
        imm = {{(`CORE_XLEN-21){sign}}, inst[31], inst[19:12], inst[20],
               inst[30:21], 1'b0};
      end
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu (
  input  core_pkg::xlen_t   a,
  input  core_pkg::xlen_t   b,
  input  core_pkg::alu_op_e op,
  output core_pkg::xlen_t   result
);
  import core_pkg::*;

  logic [5:0] shamt;

  assign shamt = b[5:0];  // RV64 shift amount.

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      ALU_SLT:    result = xlen_t'($signed(a) < $signed(b));
      ALU_SLTU:   result = xlen_t'(a < b);
      ALU_SLL:    result = a << shamt;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;  // Sign fill.
      ALU_COPY_B: result = b;
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none

module register_file (
  input  logic               clk,
  input  logic               rst_n,
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  input  core_pkg::reg_idx_t rd,
  input  logic               wen,
  input  core_pkg::xlen_t    wdata,
  output core_pkg::xlen_t    rs1_data,
  output core_pkg::xlen_t    rs2_data
);
  import core_pkg::*;

  xlen_t regs [1:31];  // No storage behind x0.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
`default_nettype none

`include "core_settings.svh"

module data_memory (
  input  logic            clk,
  input  core_pkg::xlen_t addr,
  input  core_pkg::xlen_t wdata,
  input  logic            wen,
  input  logic            ren,
  output core_pkg::xlen_t rdata
);
  import core_pkg::*;

  localparam int DEPTH = 2 ** `CORE_DMEM_AW;

  xlen_t                  mem [DEPTH];
  logic [`CORE_DMEM_AW-1:0] idx;

  // Byte offset bits are dropped, accesses are whole doublewords.
  assign idx = addr[`CORE_DMEM_AW+2:3];

  assign rdata = ren ? mem[idx] : '0;

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[idx] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
`default_nettype none

`include "core_settings.svh"

module core_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     run,
  input  logic                     imem_we,
  input  logic [`CORE_IMEM_AW-1:0] imem_addr,
  input  core_pkg::inst_t          imem_wdata,
  output core_pkg::retire_t        retire,
  output logic                     retire_valid,
  output logic                     halted,
  output logic                     illegal
);
  import core_pkg::*;

  localparam int IMEM_DEPTH = 2 ** `CORE_IMEM_AW;

  inst_t    imem [IMEM_DEPTH];
  xlen_t    pc, snpc, dnpc;
  inst_t    inst;
  ctrl_t    ctrl;
  reg_idx_t rs1, rs2, rd;
  xlen_t    imm, rs1_data, rs2_data;
  xlen_t    alu_a, alu_b, alu_res;
  xlen_t    mem_rdata, wb_data;
  logic     step;

  // Program load, only while held in reset.
  always_ff @(posedge clk) begin
    if (!rst_n && imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  assign inst = imem[pc[`CORE_IMEM_AW+1:2]];
  assign rs1  = inst[19:15];
  assign rs2  = inst[24:20];
  assign rd   = inst[11:7];
  assign step = run && !halted;

  control u_control (
    .inst     (inst),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ctrl     (ctrl)
  );

  imm_gen u_imm_gen (
    .inst (inst),
    .kind (ctrl.imm_kind),
    .imm  (imm)
  );

  register_file u_register_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .wen      (ctrl.reg_wen && step),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = (ctrl.alu_a_sel == A_PC) ? pc : rs1_data;
  assign alu_b = (ctrl.alu_b_sel == B_IMM) ? imm : rs2_data;

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_res)
  );

  data_memory u_data_memory (
    .clk   (clk),
    .addr  (alu_res),
    .wdata (rs2_data),
    .wen   (ctrl.mem_wen && step),
    .ren   (ctrl.mem_ren),
    .rdata (mem_rdata)
  );

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = mem_rdata;
      WB_SNPC: wb_data = snpc;  // Link address.
      default: wb_data = alu_res;
    endcase
  end

  assign snpc = pc + xlen_t'(`CORE_INST_LEN);
  // Bit 0 cleared for JALR, already zero for the other targets.
  assign dnpc = ctrl.pc_from_alu ? {alu_res[`CORE_XLEN-1:1], 1'b0} : snpc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= `CORE_PC_INIT;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (step) begin
      pc <= dnpc;
      if (ctrl.halt) begin
        halted  <= 1'b1;  // Sticky until reset.
        illegal <= ctrl.illegal;
      end
    end
  end

  assign retire_valid = step;
  assign retire = '{pc: pc, inst: inst, rd_wen: ctrl.reg_wen, rd: rd, rd_data: wb_data};

endmodule

`default_nettype wire

// ==== bench/core_sva.sv ====
`default_nettype none

module core_sva (
  input logic            clk,
  input logic            rst_n,
  input logic            retire_valid,
  input logic            halted,
  input core_pkg::xlen_t pc
);

  // A halted core commits nothing and keeps its PC.
  a_no_retire_halted: assert property (
    @(posedge clk) disable iff (!rst_n) halted |=> !retire_valid && $stable(pc))
    else $error("core retired or moved its pc while halted");

  // Only reset may clear the halt flag.
  a_halt_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) halted |=> halted)
    else $error("halted fell without a reset");

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc is not 4-byte aligned");

endmodule

bind core_top core_sva u_core_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .retire_valid (retire_valid),
  .halted       (halted),
  .pc           (pc)
);

`default_nettype wire

// ==== bench/core_tb.sv ====
`default_nettype none

`include "core_settings.svh"

module core_tb;
  import core_pkg::*;

  localparam int NUM_ROWS     = 36;
  localparam int PAUSE_ROW    = 18;  // Run drops after this row retires.
  localparam int PAUSE_CYCLES = 6;
  localparam int TIMEOUT      = 20;
  localparam int HALT_WINDOW  = 12;
  localparam int AW           = `CORE_IMEM_AW;

  typedef struct packed {
    inst_t    inst;
    logic     skip;  // Jumped over, never retires.
    logic     rd_wen;
    reg_idx_t rd;
    xlen_t    rd_data;
  } row_t;

  logic          clk;
  logic          rst_n;
  logic          run;
  logic          imem_we;
  logic [AW-1:0] imem_addr;
  inst_t         imem_wdata;
  retire_t       retire;
  logic          retire_valid;
  logic          halted;
  logic          illegal;

  // Row i sits at byte address 4 * i.
  row_t rows [NUM_ROWS] = '{
    '{32'h0050_0093, 1'b0, 1'b1, 5'd1,  64'h5},                    // addi x1, x0, 5
    '{32'hFFD0_0113, 1'b0, 1'b1, 5'd2,  64'hFFFF_FFFF_FFFF_FFFD},  // addi x2, x0, -3
    '{32'h1234_51B7, 1'b0, 1'b1, 5'd3,  64'h0000_0000_1234_5000},  // lui x3, 0x12345
    '{32'h8000_0237, 1'b0, 1'b1, 5'd4,  64'hFFFF_FFFF_8000_0000},  // lui x4, 0x80000
    '{32'h0000_1297, 1'b0, 1'b1, 5'd5,  64'h1010},                 // auipc x5, 1
    '{32'h0020_8333, 1'b0, 1'b1, 5'd6,  64'h2},                    // add x6, x1, x2
    '{32'h4011_03B3, 1'b0, 1'b1, 5'd7,  64'hFFFF_FFFF_FFFF_FFF8},  // sub x7, x2, x1
    '{32'h0020_F433, 1'b0, 1'b1, 5'd8,  64'h5},                    // and x8, x1, x2
    '{32'h0011_E4B3, 1'b0, 1'b1, 5'd9,  64'h0000_0000_1234_5005},  // or x9, x3, x1
    '{32'h0041_4533, 1'b0, 1'b1, 5'd10, 64'h0000_0000_7FFF_FFFD},  // xor x10, x2, x4
    '{32'h0011_25B3, 1'b0, 1'b1, 5'd11, 64'h1},                    // slt x11, x2, x1
    '{32'h0011_3633, 1'b0, 1'b1, 5'd12, 64'h0},                    // sltu x12, x2, x1
    '{32'h0010_96B3, 1'b0, 1'b1, 5'd13, 64'hA0},                   // sll x13, x1, x1
    '{32'h0012_5733, 1'b0, 1'b1, 5'd14, 64'h07FF_FFFF_FC00_0000},  // srl x14, x4, x1
    '{32'h4012_57B3, 1'b0, 1'b1, 5'd15, 64'hFFFF_FFFF_FC00_0000},  // sra x15, x4, x1
    '{32'h0010_8033, 1'b0, 1'b1, 5'd0,  64'hA},                    // add x0, x1, x1
    '{32'h0010_0833, 1'b0, 1'b1, 5'd16, 64'h5},                    // add x16, x0, x1
    '{32'h0030_3823, 1'b0, 1'b0, 5'd0,  64'h0},                    // sd x3, 16(x0)
    '{32'h0070_3C23, 1'b0, 1'b0, 5'd0,  64'h0},                    // sd x7, 24(x0)
    '{32'h0100_3883, 1'b0, 1'b1, 5'd17, 64'h0000_0000_1234_5000},  // ld x17, 16(x0)
    '{32'h0180_3903, 1'b0, 1'b1, 5'd18, 64'hFFFF_FFFF_FFFF_FFF8},  // ld x18, 24(x0)
    '{32'h0100_8463, 1'b0, 1'b0, 5'd0,  64'h0},                    // beq x1, x16, +8
    '{32'h0010_0993, 1'b1, 1'b0, 5'd0,  64'h0},                    // addi x19, x0, 1
    '{32'h0011_4463, 1'b0, 1'b0, 5'd0,  64'h0},                    // blt x2, x1, +8
    '{32'h0020_0993, 1'b1, 1'b0, 5'd0,  64'h0},                    // addi x19, x0, 2
    '{32'h0100_9463, 1'b0, 1'b0, 5'd0,  64'h0},                    // bne x1, x16, +8
    '{32'h00C0_0A6F, 1'b0, 1'b1, 5'd20, 64'h6C},                   // jal x20, +12
    '{32'h0030_0993, 1'b1, 1'b0, 5'd0,  64'h0},                    // addi x19, x0, 3
    '{32'h0040_0993, 1'b1, 1'b0, 5'd0,  64'h0},                    // addi x19, x0, 4
    '{32'h0850_0A93, 1'b0, 1'b1, 5'd21, 64'h85},                   // addi x21, x0, 0x85
    '{32'h000A_8B67, 1'b0, 1'b1, 5'd22, 64'h7C},                   // jalr x22, 0(x21)
    '{32'h0050_0993, 1'b1, 1'b0, 5'd0,  64'h0},                    // addi x19, x0, 5
    '{32'h0060_0993, 1'b1, 1'b0, 5'd0,  64'h0},                    // addi x19, x0, 6
    '{32'h001B_0B93, 1'b0, 1'b1, 5'd23, 64'h7D},                   // addi x23, x22, 1
    '{32'h0009_8C33, 1'b0, 1'b1, 5'd24, 64'h0},                    // add x24, x19, x0
    '{32'h0010_0073, 1'b0, 1'b0, 5'd0,  64'h0}                     // ebreak
  };

  core_top u_core_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .retire       (retire),
    .retire_valid (retire_valid),
    .halted       (halted),
    .illegal      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_failed();
    $display("TB FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_eq(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  // Returns at the negedge inside the retiring cycle.
  task automatic wait_retire(input int row);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = retire_valid;
    end
    if (!seen) begin
      $display("timeout: no retirement seen for row %0d", row);
      stop_failed();
    end
  endtask

  task automatic wait_halt();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = halted;
    end
    if (!seen) begin
      $display("timeout: halted did not rise after ebreak");
      stop_failed();
    end
  endtask

  task automatic pause_core();
    @(posedge clk);
    run <= 1'b0;
    for (int n = 0; n < PAUSE_CYCLES; n++) begin
      @(negedge clk);
      if (retire_valid) begin
        $display("retire_valid pulsed while run was low");
        stop_failed();
      end
    end
    @(posedge clk);
    run <= 1'b1;
  endtask

  initial begin
    rst_n      = 1'b0;
    run        = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;

    // Core stays in reset for the whole load.
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= AW'(i);
      imem_wdata <= rows[i].inst;
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_eq("retire_valid after reset", xlen_t'(retire_valid), '0);
    check_eq("halted after reset", xlen_t'(halted), '0);
    check_eq("illegal after reset", xlen_t'(illegal), '0);
    check_eq("pc after reset", retire.pc, `CORE_PC_INIT);

    @(posedge clk);
    run <= 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (!rows[i].skip) begin
        wait_retire(i);
        check_eq($sformatf("row %0d pc", i), retire.pc, xlen_t'(i * 4));
        check_eq($sformatf("row %0d inst", i), xlen_t'(retire.inst), xlen_t'(rows[i].inst));
        check_eq($sformatf("row %0d rd_wen", i), xlen_t'(retire.rd_wen),
                 xlen_t'(rows[i].rd_wen));
        if (rows[i].rd_wen) begin
          check_eq($sformatf("row %0d rd", i), xlen_t'(retire.rd), xlen_t'(rows[i].rd));
          check_eq($sformatf("row %0d rd_data", i), retire.rd_data, rows[i].rd_data);
        end
        if (i == PAUSE_ROW) begin
          pause_core();
        end
      end
    end

    wait_halt();
    check_eq("illegal after ebreak", xlen_t'(illegal), '0);
    for (int n = 0; n < HALT_WINDOW; n++) begin
      @(negedge clk);
      if (retire_valid) begin
        $display("retire_valid pulsed after the core halted");
        stop_failed();
      end
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
design/core_pkg.sv
design/control.sv
design/imm_gen.sv
design/alu.sv
design/register_file.sv
design/data_memory.sv
design/core_top.sv
bench/core_sva.sv
bench/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module core_tb \
    --Mdir obj_dir -o core_tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/core_tb_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^TB PASSED$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
